//--- fifo_pkg.sv
// FIFO-side definitions shared by the feeder, the debug FIFO and the demo top level
package fifo_pkg;

    // --------------------------------------------------
    // FIFO geometry
    // --------------------------------------------------

    localparam int fifo_width = 4;
    localparam int fifo_depth = 8;
    localparam int ptr_width  = 3;
    // One extra bit so a full FIFO can count to fifo_depth
    localparam int cnt_width  = 4;

    // Pattern table size and the index that walks it
    localparam int pattern_len = 16;
    localparam int idx_width   = 4;

    // Operation taken on one tick after flag gating
    typedef enum logic [1:0]
    {
        op_idle,
        op_push,
        op_pop,
        op_push_pop
    } key_op_e;

    // Scrambled write values, entry 0 is pushed first
    localparam logic [0:pattern_len - 1][fifo_width - 1:0] pattern_table =
        '{ 4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
           4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3 };

    // Live view of the whole FIFO state for the display and LEDs
    typedef struct packed
    {
        logic [fifo_depth - 1:0]                   valid;
        logic [fifo_depth - 1:0][fifo_width - 1:0] data;
        logic [ptr_width  - 1:0]                   wr_ptr;
        logic [ptr_width  - 1:0]                   rd_ptr;
        logic [cnt_width  - 1:0]                   count;
        logic                                      empty;
        logic                                      full;
    } fifo_debug_t;

endpackage

//--- display_pkg.sv
// Seven-segment display definitions and the hex decoder, used by the scanner and its model
package display_pkg;

    // Number of multiplexed digits on the board
    localparam int w_digit  = 8;

    // Clocks spent on each digit while scanning
    localparam int scan_div = 4;

    // Segment bits, all active high, h is the decimal point
    typedef struct packed
    {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic h;
    } seg_t;

    // A lone dash marks a slot that holds nothing
    localparam seg_t sign_empty_entry = 8'b0000_0010;

    // --------------------------------------------------
    // Hex digit to segment pattern, dot left off
    // --------------------------------------------------

    function automatic seg_t hex_to_seg(input logic [3:0] value);
        seg_t seg;
        case (value)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

endpackage

//--- tick_gen.sv
// Slow tick strobe for the demo, one clock wide every tick_div board clocks
module tick_gen
#(
    parameter int tick_div = 50_000_000
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    // Wide enough to hold tick_div - 1, at least one bit
    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w - 1:0] cnt;

    // Wrapping divider counter
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (cnt == cnt_w'(tick_div - 1))
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // Strobe on the last count so the tick_div-th edge sees it
    assign tick = (cnt == cnt_w'(tick_div - 1));

endmodule

//--- fifo_feeder.sv
// Turns held key levels into FIFO push and pop on each tick and supplies pattern data
module fifo_feeder
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tick,
    input  logic [1:0]                      key,
    input  logic                            empty,
    input  logic                            full,
    output logic                            push,
    output logic                            pop,
    output logic [fifo_pkg::fifo_width - 1:0] write_data
);

    fifo_pkg::key_op_e                 op;
    logic [fifo_pkg::idx_width - 1:0]  pattern_idx;
    logic                              push_ok;
    logic                              pop_ok;

    // --------------------------------------------------
    // Request gating against the current flags
    // --------------------------------------------------

    // key[1] asks for push, key[0] asks for pop
    assign push_ok = key[1] & ~full;
    assign pop_ok  = key[0] & ~empty;

    always_comb
    begin
        op = fifo_pkg::op_idle;
        if (tick)
        begin
            case ({push_ok, pop_ok})
                2'b10:   op = fifo_pkg::op_push;
                2'b01:   op = fifo_pkg::op_pop;
                2'b11:   op = fifo_pkg::op_push_pop;
                default: op = fifo_pkg::op_idle;
            endcase
        end
    end

    // Both strobes come straight from the operation
    assign push = (op == fifo_pkg::op_push) || (op == fifo_pkg::op_push_pop);
    assign pop  = (op == fifo_pkg::op_pop)  || (op == fifo_pkg::op_push_pop);

    // --------------------------------------------------
    // Pattern index
    // --------------------------------------------------

    // Steps with each accepted push, wraps after the last entry
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pattern_idx <= '0;
        else if (push)
            pattern_idx <= pattern_idx + 1'b1;
    end

    // Data for the next push
    assign write_data = fifo_pkg::pattern_table[pattern_idx];

endmodule

//--- debug_fifo.sv
// Flip-flop FIFO with empty and full flags that also exposes its whole state for display
module debug_fifo
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push,
    input  logic                              pop,
    input  logic [fifo_pkg::fifo_width - 1:0] write_data,
    output logic [fifo_pkg::fifo_width - 1:0] read_data,
    output fifo_pkg::fifo_debug_t             dbg
);

    localparam int depth = fifo_pkg::fifo_depth;
    localparam int pw    = fifo_pkg::ptr_width;
    localparam int cw    = fifo_pkg::cnt_width;

    logic [depth - 1:0][fifo_pkg::fifo_width - 1:0] mem;
    logic [depth - 1:0]                             valid;
    logic [pw - 1:0]                                wr_ptr;
    logic [pw - 1:0]                                rd_ptr;
    logic [cw - 1:0]                                count;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    // Payload only, the valid bits say what is live
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= write_data;
    end

    // Occupancy per slot, set on write and cleared on read
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid <= '0;
        else
        begin
            if (pop)
                valid[rd_ptr] <= 1'b0;
            if (push)
                valid[wr_ptr] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Pointers and count
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Pointers wrap at the last slot
            if (push)
                wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            // Push with pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry
    assign read_data = mem[rd_ptr];

    // --------------------------------------------------
    // Debug view, straight from the registers
    // --------------------------------------------------

    assign dbg.valid  = valid;
    assign dbg.data   = mem;
    assign dbg.wr_ptr = wr_ptr;
    assign dbg.rd_ptr = rd_ptr;
    assign dbg.count  = count;
    assign dbg.empty  = (count == '0);
    assign dbg.full   = (count == cw'(depth));

endmodule

//--- seg_display.sv
// Multiplexed eight-digit scanner showing FIFO slots, empty dashes and pointer dots
module seg_display
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  fifo_pkg::fifo_debug_t               dbg,
    output display_pkg::seg_t                   abcdefgh,
    output logic [display_pkg::w_digit - 1:0]   digit
);

    localparam int n_digit = display_pkg::w_digit;
    localparam int div_w   = (display_pkg::scan_div > 1) ? $clog2(display_pkg::scan_div) : 1;
    localparam int slot_w  = $clog2(n_digit);

    logic [div_w - 1:0]  div_cnt;
    logic [slot_w - 1:0] slot;
    logic                dot;
    display_pkg::seg_t   seg;

    // --------------------------------------------------
    // Scan timing
    // --------------------------------------------------

    // Hold each digit for scan_div clocks, then step to the next slot
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            slot    <= '0;
        end
        else if (div_cnt == div_w'(display_pkg::scan_div - 1))
        begin
            div_cnt <= '0;
            // Slot 0 follows the last one
            slot    <= (slot == slot_w'(n_digit - 1)) ? '0 : slot + 1'b1;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // --------------------------------------------------
    // Segment selection
    // --------------------------------------------------

    // Pointer marks on the shown slot
    assign dot = (slot == dbg.wr_ptr) || (slot == dbg.rd_ptr);

    always_comb
    begin
        // Live slots show their value, the rest a dash
        if (dbg.valid[slot])
            seg = display_pkg::hex_to_seg(dbg.data[slot]);
        else
            seg = display_pkg::sign_empty_entry;
        seg.h = dot;
    end

    assign abcdefgh = seg;

    // Slot 0 sits on the leftmost digit, position 7
    assign digit = n_digit'(1) << (n_digit - 1 - slot);

endmodule

//--- fifo_demo_top.sv
// Board top level of the key-driven FIFO demo, wiring ticks, feeder, FIFO, display and LEDs
module fifo_demo_top
#(
    parameter int tick_div = 50_000_000
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        key,
    output logic [7:0]        led,
    output display_pkg::seg_t abcdefgh,
    output logic [7:0]        digit
);

    logic                              tick;
    logic                              push;
    logic                              pop;
    logic [fifo_pkg::fifo_width - 1:0] write_data;
    fifo_pkg::fifo_debug_t             dbg;

    // --------------------------------------------------
    // Key handling at the tick rate
    // --------------------------------------------------

    tick_gen #(.tick_div(tick_div)) tick_gen_inst
    (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // Flags come back from the FIFO's debug view
    fifo_feeder fifo_feeder_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .key        (key),
        .empty      (dbg.empty),
        .full       (dbg.full),
        .push       (push),
        .pop        (pop),
        .write_data (write_data)
    );

    // --------------------------------------------------
    // FIFO and display
    // --------------------------------------------------

    // Nothing on the board consumes popped data
    debug_fifo debug_fifo_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .pop        (pop),
        .write_data (write_data),
        .read_data  (),
        .dbg        (dbg)
    );

    seg_display seg_display_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .dbg      (dbg),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // Full and empty on the top two LEDs, count on the low four
    assign led = {dbg.full, dbg.empty, 2'b00, dbg.count};

endmodule

//--- tb_clock.sv
// Testbench clock and reset source, instantiated once by the FIFO demo testbench
module tb_clock
(
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 10;
    localparam int reset_cycles = 5;

    // Free-running 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset held for five cycles, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_fifo_demo.sv
// Testbench for the key-driven FIFO demo, random keys checked against a reference model
module tb_fifo_demo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int tick_div     = 8;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 5;
    localparam int random_ticks = 400;
    // Directed phases plus the random run, in ticks
    localparam int total_ticks  = 2 + 12 + 4 + 12 + random_ticks;
    localparam int margin       = 200;

    // Write values in push order
    localparam logic [3:0] pattern [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3 };

    logic       clk;
    logic       rst_n;
    logic [1:0] key;
    logic [7:0] led;
    logic [7:0] abcdefgh;
    logic [7:0] digit;

    // Reference model state
    logic [3:0]  m_data [0:7];
    logic [7:0]  m_valid;
    logic [3:0]  m_queue [$];
    int          m_wr;
    int          m_rd;
    int          m_idx;
    logic [31:0] lfsr;
    int          edge_n;

    tb_clock tb_clock_inst
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fifo_demo_top #(.tick_div(tick_div)) fifo_demo_top_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per random bit
    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // Segments a..g then the dot, active high
    function automatic logic [7:0] segment_code(input logic [3:0] v);
        logic [7:0] s;
        case (v)
            4'h0:    s = 8'hfc;
            4'h1:    s = 8'h60;
            4'h2:    s = 8'hda;
            4'h3:    s = 8'hf2;
            4'h4:    s = 8'h66;
            4'h5:    s = 8'hb6;
            4'h6:    s = 8'hbe;
            4'h7:    s = 8'he0;
            4'h8:    s = 8'hfe;
            4'h9:    s = 8'hf6;
            4'ha:    s = 8'hee;
            4'hb:    s = 8'h3e;
            4'hc:    s = 8'h9c;
            4'hd:    s = 8'h7a;
            4'he:    s = 8'h9e;
            default: s = 8'h8e;
        endcase
        return s;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Requests are gated by the flags as they stood before the tick
    task automatic model_tick(input logic [1:0] k);
        bit push_ok;
        bit pop_ok;
        push_ok = k[1] && (m_queue.size() < 8);
        pop_ok  = k[0] && (m_queue.size() > 0);
        if (pop_ok)
        begin
            m_valid[m_rd] = 1'b0;
            m_rd          = (m_rd + 1) % 8;
            m_queue.delete(0);
        end
        // Refused pushes leave the pattern index where it is
        if (push_ok)
        begin
            m_data[m_wr]  = pattern[m_idx];
            m_valid[m_wr] = 1'b1;
            m_queue.push_back(pattern[m_idx]);
            m_wr          = (m_wr + 1) % 8;
            m_idx         = (m_idx + 1) % 16;
        end
    endtask

    // LEDs and the currently scanned digit against the model
    task automatic check_outputs();
        int         pos;
        int         slot;
        int         cnt;
        logic [7:0] exp_led;
        logic [7:0] exp_seg;
        cnt     = m_queue.size();
        exp_led = {cnt == 8, cnt == 0, 2'b00, 4'(cnt)};
        check_value("led", led, exp_led);
        check_value("digit one-hot", $onehot(digit), 1);
        pos = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (digit[i])
                pos = i;
        end
        // Leftmost position shows slot 0
        slot    = 7 - pos;
        exp_seg = m_valid[slot] ? segment_code(m_data[slot]) : 8'h02;
        exp_seg[0] = (slot == m_wr) || (slot == m_rd);
        check_value("abcdefgh", abcdefgh, exp_seg);
    endtask

    // Keys change on falling edges, the model steps on tick edges
    task automatic run_phase(input int n_ticks, input fifo_pkg::key_op_e hold,
                             input bit random_keys);
        logic b1;
        logic b0;
        repeat (n_ticks * tick_div)
        begin
            if (random_keys)
            begin
                draw_bit(b1);
                draw_bit(b0);
                key = {b1, b0};
            end
            else
                key = {hold == fifo_pkg::op_push || hold == fifo_pkg::op_push_pop,
                       hold == fifo_pkg::op_pop  || hold == fifo_pkg::op_push_pop};
            @(posedge clk);
            edge_n++;
            if (edge_n % tick_div == 0)
                model_tick(key);
            @(negedge clk);
            check_outputs();
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial
    begin
        key         = 2'b00;
        lfsr        = 32'h83b73f8b;
        edge_n      = 0;
        m_valid     = '0;
        m_wr        = 0;
        m_rd        = 0;
        m_idx       = 0;
        @(posedge rst_n);
        // Empty FIFO, scan on position 7 with both pointers there
        check_value("led", led, 8'h40);
        check_value("digit", digit, 8'h80);
        check_value("abcdefgh", abcdefgh, 8'h03);
        run_phase(2, fifo_pkg::op_idle, 1'b0);
        // Fill past full, extra pushes are dropped
        run_phase(12, fifo_pkg::op_push, 1'b0);
        check_value("led full", led[7], 1);
        check_value("led count", led[3:0], 8);
        // First tick only pops, then both move together
        run_phase(4, fifo_pkg::op_push_pop, 1'b0);
        check_value("led count", led[3:0], 7);
        // Drain past empty
        run_phase(12, fifo_pkg::op_pop, 1'b0);
        check_value("led", led, 8'h40);
        run_phase(random_ticks, fifo_pkg::op_idle, 1'b1);
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog sized from the phase lengths
    initial
    begin
        #((total_ticks * tick_div + reset_cycles + margin) * clk_period);
        $display("Timeout: the run went past its expected number of clocks");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim.f
fifo_pkg.sv
display_pkg.sv
tick_gen.sv
fifo_feeder.sv
debug_fifo.sv
seg_display.sv
fifo_demo_top.sv
tb_clock.sv
tb_fifo_demo.sv

//--- run.sh
#!/bin/sh
# Builds the FIFO demo testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_fifo_demo -f sim.f -o sim_fifo_demo

./obj_dir/sim_fifo_demo > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
